// File: files.f
hw/wave_pkg.sv
hw/wave_mem_if.sv
hw/wave_sample_ram.sv
hw/rate_timer.sv
hw/playback_ctrl.sv
hw/wave_host_regs.sv
hw/waveform_gen_top.sv
tests/waveform_gen_assertions.sv
tests/tb_waveform_gen.sv

// File: hw/playback_ctrl.sv
`timescale 1ns/1ps

module playback_ctrl (
    input  logic                                  ep50trig,
    input  logic                                  reset_global,
    input  logic                                  run,
    input  logic                                  tick,
    input  logic [$bits(wave_pkg::sample_idx_t):0] length,
    wave_mem_if.player                            mem,
    output wave_pkg::wave_sample_t                wave,
    output logic                                  wave_strobe,
    output logic                                  playing,
    output wave_pkg::sample_idx_t                 sample_index
);
    import wave_pkg::*;

    play_state_t  state;
    sample_idx_t  idx;
    // low half, held while the high word is read
    wave_word_t   lo_word;
    // last presented sample
    wave_sample_t wave_q;
    // samples played once idx is done
    logic [$bits(sample_idx_t):0] next_count;
    logic         last_sample;

    assign next_count  = {1'b0, idx} + 1'b1;
    // >= so a shorter length written mid-run still wraps
    assign last_sample = (next_count >= length);

    //////////////////////////////////////////////////////////////////////
    // fsm
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge ep50trig)
    begin
        if (reset_global)
        begin
            state  <= PLAY_IDLE;
            idx    <= '0;
            wave_q <= '0;
        end
        else
        begin
            case (state)
                PLAY_IDLE:
                begin
                    idx <= '0;
                    if (run)
                    begin
                        state <= PLAY_WAIT;
                    end
                end
                PLAY_WAIT:
                begin
                    if (!run)
                    begin
                        state <= PLAY_IDLE;
                        idx   <= '0;
                    end
                    else if (tick)
                    begin
                        state <= PLAY_FETCH_LO;
                    end
                end
                // fetch runs to the end even if run drops
                PLAY_FETCH_LO:
                begin
                    state <= PLAY_FETCH_HI;
                end
                PLAY_FETCH_HI:
                begin
                    state <= PLAY_PRESENT;
                end
                PLAY_PRESENT:
                begin
                    wave_q <= {mem.rd_data, lo_word};
                    if (!run)
                    begin
                        state <= PLAY_IDLE;
                        idx   <= '0;
                    end
                    else
                    begin
                        state <= PLAY_WAIT;
                        idx   <= last_sample ? '0 : next_count[$bits(sample_idx_t)-1:0];
                    end
                end
                default:
                begin
                    state <= PLAY_IDLE;
                end
            endcase
        end
    end

    // low word arrives during FETCH_HI
    always_ff @(posedge ep50trig)
    begin
        if (state == PLAY_FETCH_HI)
        begin
            lo_word <= mem.rd_data;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // ram reads and outputs
    //////////////////////////////////////////////////////////////////////

    // word address 2*idx, then 2*idx+1
    assign mem.rd_en   = (state == PLAY_FETCH_LO) || (state == PLAY_FETCH_HI);
    assign mem.rd_addr = {idx, (state == PLAY_FETCH_HI)};

    // high word is live in PRESENT, sample shows up with the strobe
    assign wave_strobe  = (state == PLAY_PRESENT);
    assign wave         = wave_strobe ? {mem.rd_data, lo_word} : wave_q;
    assign playing      = (state != PLAY_IDLE);
    assign sample_index = idx;

endmodule

// File: hw/rate_timer.sv
`timescale 1ns/1ps

module rate_timer (
    input  logic                ep50trig,
    input  logic                reset_global,
    input  logic                run,
    input  wave_pkg::half_cnt_t half_cnt,
    input  logic                half_cnt_load,
    output logic                tick
);
    import wave_pkg::*;

    // cycles left before the next tick
    half_cnt_t count;

    //////////////////////////////////////////////////////////////////////
    // down-counter
    //////////////////////////////////////////////////////////////////////

    // period is half_cnt plus one, counts half_cnt down to 0 then
    // spends one more cycle on the terminal count
    always_ff @(posedge ep50trig)
    begin
        if (reset_global)
        begin
            count <= HALF_CNT_RESET;
            tick  <= 1'b0;
        end
        else if (!run || half_cnt_load)
        begin
            // stopped or new rate, start a fresh period
            count <= half_cnt;
            tick  <= 1'b0;
        end
        else if (count == '0)
        begin
            // terminal count, fire and reload
            count <= half_cnt;
            tick  <= 1'b1;
        end
        else
        begin
            count <= count - 1'b1;
            tick  <= 1'b0;
        end
    end

endmodule

// File: hw/wave_host_regs.sv
`timescale 1ns/1ps

module wave_host_regs (
    input  logic                                   ep50trig,
    input  logic                                   reset_global,
    input  wave_pkg::apb_addr_t                    paddr,
    input  logic                                   psel,
    input  logic                                   penable,
    input  logic                                   pwrite,
    input  wave_pkg::apb_data_t                    pwdata,
    output wave_pkg::apb_data_t                    prdata,
    output logic                                   pready,
    output logic                                   pslverr,
    wave_mem_if.host                               mem,
    output logic                                   run,
    output wave_pkg::half_cnt_t                    half_cnt,
    output logic                                   half_cnt_load,
    output logic [$bits(wave_pkg::sample_idx_t):0] length,
    input  logic                                   playing,
    input  wave_pkg::sample_idx_t                  sample_index,
    input  wave_pkg::wave_sample_t                 wave
);
    import wave_pkg::*;

    // access phase, completes this cycle since pready is tied high
    logic      access;
    logic      wr_access;
    logic      addr_mapped;
    logic      addr_read_only;
    // word pointer for sample loads
    ram_addr_t wptr;
    // clamped write values
    half_cnt_t half_cnt_wr;
    logic [$bits(sample_idx_t):0] length_raw;
    logic [$bits(sample_idx_t):0] length_wr;

    assign access    = psel && penable;
    assign wr_access = access && pwrite && addr_mapped && !addr_read_only;
    assign pready    = 1'b1;

    //////////////////////////////////////////////////////////////////////
    // decode and clamps
    //////////////////////////////////////////////////////////////////////

    assign addr_read_only = (paddr == REG_WAVE) || (paddr == REG_STATUS);

    // rate floor
    assign half_cnt_wr = (pwdata[$bits(half_cnt_t)-1:0] < HALF_CNT_MIN) ?
                         HALF_CNT_MIN : pwdata[$bits(half_cnt_t)-1:0];

    // 0 means full length, anything past it saturates
    assign length_raw = pwdata[$bits(sample_idx_t):0];
    assign length_wr  = ((length_raw == '0) || (length_raw > MAX_LENGTH)) ?
                        MAX_LENGTH : length_raw;

    // unmapped address, or a write to a read-only register
    assign pslverr = access && (!addr_mapped || (pwrite && addr_read_only));

    //////////////////////////////////////////////////////////////////////
    // registers
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge ep50trig)
    begin
        if (reset_global)
        begin
            run           <= 1'b0;
            half_cnt      <= HALF_CNT_RESET;
            half_cnt_load <= 1'b0;
            length        <= LENGTH_RESET;
            wptr          <= '0;
        end
        else
        begin
            // one-cycle pulse, timer reloads from the new value
            half_cnt_load <= wr_access && (paddr == REG_HALF_CNT);
            if (wr_access)
            begin
                case (paddr)
                    REG_CTRL:     run      <= pwdata[0];
                    REG_HALF_CNT: half_cnt <= half_cnt_wr;
                    REG_LENGTH:   length   <= length_wr;
                    REG_WPTR:     wptr     <= pwdata[$bits(ram_addr_t)-1:0];
                    // wraps at RAM_DEPTH by width
                    REG_WDATA:    wptr     <= wptr + 1'b1;
                    default:      wptr     <= wptr;
                endcase
            end
        end
    end

    // sample load, written at the edge that ends the access
    assign mem.wr_en   = wr_access && (paddr == REG_WDATA);
    assign mem.wr_addr = wptr;
    assign mem.wr_data = pwdata[$bits(wave_word_t)-1:0];

    //////////////////////////////////////////////////////////////////////
    // readback
    //////////////////////////////////////////////////////////////////////

    always_comb
    begin
        addr_mapped = 1'b1;
        prdata      = '0;
        case (paddr)
            REG_CTRL:     prdata[0] = run;
            REG_HALF_CNT: prdata[$bits(half_cnt_t)-1:0] = half_cnt;
            REG_LENGTH:   prdata[$bits(sample_idx_t):0] = length;
            REG_WPTR:     prdata[$bits(ram_addr_t)-1:0] = wptr;
            // write-only data port reads as zero
            REG_WDATA:    prdata = '0;
            REG_WAVE:     prdata = wave;
            REG_STATUS:
            begin
                prdata[0]    = playing;
                prdata[15:8] = sample_index;
            end
            default:      addr_mapped = 1'b0;
        endcase
    end

endmodule

// File: hw/wave_mem_if.sv
`timescale 1ns/1ps

interface wave_mem_if;
    import wave_pkg::*;

    // write port, host side
    logic       wr_en;
    ram_addr_t  wr_addr;
    wave_word_t wr_data;

    // read port, player side
    // rd_data is valid one cycle after rd_en
    logic       rd_en;
    ram_addr_t  rd_addr;
    wave_word_t rd_data;

    // register block loads words
    modport host (
        output wr_en,
        output wr_addr,
        output wr_data
    );

    // player fetches word pairs
    modport player (
        output rd_en,
        output rd_addr,
        input  rd_data
    );

    // ram sees both ports from the other side
    modport memory (
        input  wr_en,
        input  wr_addr,
        input  wr_data,
        input  rd_en,
        input  rd_addr,
        output rd_data
    );

endinterface

// File: hw/wave_pkg.sv
package wave_pkg;

    //////////////////////////////////////////////////////////////////////
    // widths and stored types
    //////////////////////////////////////////////////////////////////////

    // one word as loaded by the host
    typedef logic [15:0] wave_word_t;
    // presented sample, two words, low half first
    typedef logic [31:0] wave_sample_t;
    // word address into sample ram
    typedef logic [8:0]  ram_addr_t;
    // sample index, one sample = two words
    typedef logic [7:0]  sample_idx_t;
    // rate timer half count
    typedef logic [17:0] half_cnt_t;
    // apb byte address and data
    typedef logic [7:0]  apb_addr_t;
    typedef logic [31:0] apb_data_t;

    // player fsm
    typedef enum logic [2:0] {
        PLAY_IDLE,
        PLAY_WAIT,
        PLAY_FETCH_LO,
        PLAY_FETCH_HI,
        PLAY_PRESENT
    } play_state_t;

    //////////////////////////////////////////////////////////////////////
    // sizes and reset values
    //////////////////////////////////////////////////////////////////////

    localparam int RAM_DEPTH = 512;
    // longest waveform, two words per sample
    localparam logic [8:0] MAX_LENGTH = 9'(RAM_DEPTH / 2);
    localparam half_cnt_t HALF_CNT_RESET = 18'd16;
    // floor for the rate, keeps ticks apart from a running fetch
    localparam half_cnt_t HALF_CNT_MIN = 18'd4;
    localparam logic [8:0] LENGTH_RESET = 9'd1;

    // apb register map
    localparam apb_addr_t REG_CTRL     = 8'h00;
    localparam apb_addr_t REG_HALF_CNT = 8'h04;
    localparam apb_addr_t REG_LENGTH   = 8'h08;
    localparam apb_addr_t REG_WPTR     = 8'h0C;
    localparam apb_addr_t REG_WDATA    = 8'h10;
    localparam apb_addr_t REG_WAVE     = 8'h14;
    localparam apb_addr_t REG_STATUS   = 8'h18;

endpackage

// File: hw/wave_sample_ram.sv
`timescale 1ns/1ps

module wave_sample_ram (
    input logic        ep50trig,
    wave_mem_if.memory mem
);
    import wave_pkg::*;

    //////////////////////////////////////////////////////////////////////
    // storage
    //////////////////////////////////////////////////////////////////////

    // one 16-bit word per entry, sample n lives at 2n and 2n+1
    wave_word_t ram [RAM_DEPTH];

    // host write port
    always_ff @(posedge ep50trig)
    begin
        if (mem.wr_en)
        begin
            ram[mem.wr_addr] <= mem.wr_data;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // read port
    //////////////////////////////////////////////////////////////////////

    // registered read, word shows up the cycle after rd_en
    // same address as a write in the same cycle returns the old word
    always_ff @(posedge ep50trig)
    begin
        if (mem.rd_en)
        begin
            mem.rd_data <= ram[mem.rd_addr];
        end
    end

endmodule

// File: hw/waveform_gen_top.sv
`timescale 1ns/1ps

module waveform_gen_top (
    input  logic                   ep50trig,
    input  logic                   reset_global,
    // apb slave
    input  wave_pkg::apb_addr_t    paddr,
    input  logic                   psel,
    input  logic                   penable,
    input  logic                   pwrite,
    input  wave_pkg::apb_data_t    pwdata,
    output wave_pkg::apb_data_t    prdata,
    output logic                   pready,
    output logic                   pslverr,
    // waveform out
    output wave_pkg::wave_sample_t wave,
    output logic                   wave_strobe
);
    import wave_pkg::*;

    // control from the register block
    logic      run;
    half_cnt_t half_cnt;
    logic      half_cnt_load;
    logic [$bits(sample_idx_t):0] length;
    // timer to player
    logic      tick;
    // player status for readback
    logic        playing;
    sample_idx_t sample_index;

    // ram ports
    wave_mem_if mem_bus ();

    //////////////////////////////////////////////////////////////////////
    // blocks
    //////////////////////////////////////////////////////////////////////

    wave_host_regs u_regs (
        .ep50trig      (ep50trig),
        .reset_global  (reset_global),
        .paddr         (paddr),
        .psel          (psel),
        .penable       (penable),
        .pwrite        (pwrite),
        .pwdata        (pwdata),
        .prdata        (prdata),
        .pready        (pready),
        .pslverr       (pslverr),
        .mem           (mem_bus.host),
        .run           (run),
        .half_cnt      (half_cnt),
        .half_cnt_load (half_cnt_load),
        .length        (length),
        .playing       (playing),
        .sample_index  (sample_index),
        .wave          (wave)
    );

    rate_timer u_timer (
        .ep50trig      (ep50trig),
        .reset_global  (reset_global),
        .run           (run),
        .half_cnt      (half_cnt),
        .half_cnt_load (half_cnt_load),
        .tick          (tick)
    );

    playback_ctrl u_player (
        .ep50trig      (ep50trig),
        .reset_global  (reset_global),
        .run           (run),
        .tick          (tick),
        .length        (length),
        .mem           (mem_bus.player),
        .wave          (wave),
        .wave_strobe   (wave_strobe),
        .playing       (playing),
        .sample_index  (sample_index)
    );

    wave_sample_ram u_ram (
        .ep50trig      (ep50trig),
        .mem           (mem_bus.memory)
    );

endmodule

// File: tests/tb_waveform_gen.sv
`timescale 1ns/1ps

module tb_waveform_gen;
    import wave_pkg::*;

    // whole run is well under a thousand cycles
    localparam int CYCLE_LIMIT = 20000;
    // cycles allowed per strobe at the slowest rate of 14
    localparam int STROBE_WAIT = 200;
    localparam int PLAY_LEN    = 5;

    logic         ep50trig;
    logic         reset_global;
    apb_addr_t    paddr;
    logic         psel;
    logic         penable;
    logic         pwrite;
    apb_data_t    pwdata;
    apb_data_t    prdata;
    logic         pready;
    logic         pslverr;
    wave_sample_t wave;
    logic         wave_strobe;

    // reference words, sample n is {model[2n+1], model[2n]}
    wave_word_t   model [2*PLAY_LEN];
    // index the next strobe should present
    int           play_idx;
    int           strobe_count;
    int           last_strobe_cycle;
    int           strobe_gap;
    // model sample for the most recent strobe
    wave_sample_t last_model_sample;
    int           cycle;
    int           error_count;
    int           test_start_errors;
    int           test_num;
    int           tests_failed;
    logic [31:0]  lfsr;

    waveform_gen_top DUT (
        .ep50trig     (ep50trig),
        .reset_global (reset_global),
        .paddr        (paddr),
        .psel         (psel),
        .penable      (penable),
        .pwrite       (pwrite),
        .pwdata       (pwdata),
        .prdata       (prdata),
        .pready       (pready),
        .pslverr      (pslverr),
        .wave         (wave),
        .wave_strobe  (wave_strobe)
    );

    always #2 ep50trig = ~ep50trig;

    always @(posedge ep50trig)
    begin
        cycle <= cycle + 1;
    end

    //////////////////////////////////////////////////////////////////////
    // helpers
    //////////////////////////////////////////////////////////////////////

    task automatic check_equal(input logic [31:0] actual, input logic [31:0] expected,
                               input string what);
        assert (actual === expected)
        else
        begin
            $display("ERROR @%0t: %s, got %h expected %h", $time, what, actual, expected);
            error_count++;
        end
    endtask

    // galois form, taps for x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return (s >> 1) ^ (s[0] ? 32'h8020_0003 : 32'h0);
    endfunction

    // one lfsr step per bit taken
    task automatic next_random_word(output wave_word_t w);
        w = '0;
        for (int b = 0; b < 16; b++)
        begin
            w    = {lfsr[0], w[15:1]};
            lfsr = lfsr_step(lfsr);
        end
    endtask

    // setup cycle, access cycle, sample mid access, complete
    task automatic apb_access(input logic write, input apb_addr_t addr,
                              input apb_data_t data, output apb_data_t rdata,
                              output logic err);
        @(posedge ep50trig);
        psel    <= 1'b1;
        penable <= 1'b0;
        pwrite  <= write;
        paddr   <= addr;
        pwdata  <= data;
        @(posedge ep50trig);
        penable <= 1'b1;
        @(negedge ep50trig);
        rdata = prdata;
        err   = pslverr;
        @(posedge ep50trig);
        psel    <= 1'b0;
        penable <= 1'b0;
        pwrite  <= 1'b0;
    endtask

    task automatic reg_write(input apb_addr_t addr, input apb_data_t data);
        apb_data_t rdata;
        logic      err;
        apb_access(1'b1, addr, data, rdata, err);
        check_equal(err, 1'b0, $sformatf("pslverr on write to %h", addr));
    endtask

    task automatic reg_read_check(input apb_addr_t addr, input apb_data_t expected);
        apb_data_t rdata;
        logic      err;
        apb_access(1'b0, addr, '0, rdata, err);
        check_equal(err, 1'b0, $sformatf("pslverr on read of %h", addr));
        check_equal(rdata, expected, $sformatf("readback of %h", addr));
    endtask

    // blocks until n more strobes, or gives up
    task automatic wait_strobes(input int n);
        int target;
        int waited;
        target = strobe_count + n;
        waited = 0;
        while (strobe_count < target && waited < STROBE_WAIT * n)
        begin
            @(posedge ep50trig);
            waited++;
        end
        assert (strobe_count >= target)
        else
        begin
            $display("FAIL @%0t: waited %0d cycles for %0d strobes and saw only %0d",
                     $time, waited, n, n - (target - strobe_count));
            error_count++;
        end
    endtask

    task automatic start_test();
        test_num++;
        test_start_errors = error_count;
    endtask

    task automatic end_test(input string name);
        int errs;
        errs = error_count - test_start_errors;
        if (errs != 0)
        begin
            tests_failed++;
        end
        $display("test %0d %s: %s (%0d errors)", test_num, name,
                 (errs == 0) ? "ok" : "FAILED", errs);
    endtask

    //////////////////////////////////////////////////////////////////////
    // strobe monitor
    //////////////////////////////////////////////////////////////////////

    // every presented sample checked against the model words
    always @(negedge ep50trig)
    begin
        if (!reset_global && wave_strobe)
        begin
            last_model_sample = {model[2*play_idx+1], model[2*play_idx]};
            check_equal(wave, last_model_sample,
                        $sformatf("sample at index %0d", play_idx));
            play_idx          = (play_idx + 1) % PLAY_LEN;
            strobe_gap        = cycle - last_strobe_cycle;
            last_strobe_cycle = cycle;
            strobe_count++;
        end
    end

    // hang guard
    initial
    begin
        while (cycle < CYCLE_LIMIT)
        begin
            @(posedge ep50trig);
        end
        $display("timeout: run did not finish within %0d cycles", CYCLE_LIMIT);
        $display("Verification failed");
        $finish;
    end

    //////////////////////////////////////////////////////////////////////
    // tests
    //////////////////////////////////////////////////////////////////////

    initial
    begin
        int         snapshot;
        apb_data_t  rdata;
        logic       err;
        wave_word_t w;

        ep50trig     = 1'b0;
        reset_global = 1'b1;
        paddr        = '0;
        psel         = 1'b0;
        penable      = 1'b0;
        pwrite       = 1'b0;
        pwdata       = '0;
        lfsr         = 32'h30bb;
        play_idx     = 0;
        repeat (4) @(posedge ep50trig);
        reset_global <= 1'b0;

        // reset values with the player idle
        start_test();
        reg_read_check(REG_CTRL, 32'd0);
        reg_read_check(REG_HALF_CNT, 32'd16);
        reg_read_check(REG_LENGTH, 32'd1);
        reg_read_check(REG_WAVE, 32'd0);
        reg_read_check(REG_STATUS, 32'd0);
        repeat (40) @(posedge ep50trig);
        check_equal(strobe_count, 0, "strobes while stopped");
        end_test("reset values");

        // readback and clamps
        start_test();
        reg_write(REG_HALF_CNT, 32'd10);
        reg_read_check(REG_HALF_CNT, 32'd10);
        reg_write(REG_LENGTH, 32'd7);
        reg_read_check(REG_LENGTH, 32'd7);
        reg_write(REG_HALF_CNT, 32'd2);
        reg_read_check(REG_HALF_CNT, 32'd4);
        reg_write(REG_LENGTH, 32'd0);
        reg_read_check(REG_LENGTH, 32'd256);
        end_test("register readback");

        // bad accesses flag and leave state alone
        start_test();
        apb_access(1'b0, 8'h20, '0, rdata, err);
        check_equal(err, 1'b1, "pslverr on unmapped read");
        apb_access(1'b1, REG_WAVE, 32'hdead_beef, rdata, err);
        check_equal(err, 1'b1, "pslverr on write to WAVE");
        apb_access(1'b1, 8'h20, 32'd1, rdata, err);
        check_equal(err, 1'b1, "pslverr on unmapped write");
        reg_read_check(REG_CTRL, 32'd0);
        reg_read_check(REG_HALF_CNT, 32'd4);
        reg_read_check(REG_LENGTH, 32'd256);
        reg_read_check(REG_WAVE, 32'd0);
        end_test("error responses");

        // load five samples and play past the wrap
        start_test();
        reg_write(REG_LENGTH, PLAY_LEN);
        reg_write(REG_HALF_CNT, 32'd8);
        reg_write(REG_WPTR, 32'd0);
        for (int i = 0; i < 2 * PLAY_LEN; i++)
        begin
            next_random_word(w);
            model[i] = w;
            reg_write(REG_WDATA, {16'h0, w});
        end
        reg_read_check(REG_WPTR, 2 * PLAY_LEN);
        play_idx = 0;
        reg_write(REG_CTRL, 32'd1);
        wait_strobes(2 * PLAY_LEN + 2);
        apb_access(1'b0, REG_STATUS, '0, rdata, err);
        check_equal(rdata[0], 1'b1, "playing flag while running");
        end_test("playback order");

        // strobe spacing measured after two strobes at each new rate
        start_test();
        reg_write(REG_HALF_CNT, 32'd6);
        wait_strobes(2);
        wait_strobes(1);
        check_equal(strobe_gap, 7, "strobe spacing at half count 6");
        wait_strobes(1);
        check_equal(strobe_gap, 7, "strobe spacing at half count 6");
        reg_write(REG_HALF_CNT, 32'd13);
        wait_strobes(2);
        wait_strobes(1);
        check_equal(strobe_gap, 14, "strobe spacing at half count 13");
        wait_strobes(1);
        check_equal(strobe_gap, 14, "strobe spacing at half count 13");
        end_test("strobe rate");

        // stop, hold, restart from index 0
        start_test();
        reg_write(REG_CTRL, 32'd0);
        repeat (4) @(posedge ep50trig);
        snapshot = strobe_count;
        repeat (60) @(posedge ep50trig);
        check_equal(strobe_count, snapshot, "strobes after run cleared");
        reg_read_check(REG_WAVE, last_model_sample);
        reg_read_check(REG_STATUS, 32'd0);
        play_idx = 0;
        reg_write(REG_CTRL, 32'd1);
        wait_strobes(PLAY_LEN + 1);
        end_test("stop and restart");

        $display("tests run %0d, tests failed %0d, check errors %0d, assertion failures %0d",
                 test_num, tests_failed, error_count, DUT.u_assertions.fail_count);
        if (error_count == 0 && DUT.u_assertions.fail_count == 0)
        begin
            $display("Verification passed");
        end
        else
        begin
            $display("Verification failed");
        end
        $finish;
    end

endmodule

// File: tests/waveform_gen_assertions.sv
`timescale 1ns/1ps

module waveform_gen_assertions (
    input logic                   ep50trig,
    input logic                   reset_global,
    input logic                   psel,
    input logic                   penable,
    input logic                   pready,
    input logic                   pslverr,
    input logic                   run,
    input logic                   wave_strobe,
    input wave_pkg::wave_sample_t wave
);
    import wave_pkg::*;

    // failures seen so far, read by the testbench summary
    int fail_count = 0;

    //////////////////////////////////////////////////////////////////////
    // apb side
    //////////////////////////////////////////////////////////////////////

    // no wait states
    a_pready_high: assert property (@(posedge ep50trig) disable iff (reset_global)
        pready)
    else
    begin
        $error("pready low outside reset");
        fail_count++;
    end

    // error flag only while an access completes
    a_pslverr_access: assert property (@(posedge ep50trig) disable iff (reset_global)
        pslverr |-> (psel && penable))
    else
    begin
        $error("pslverr outside an access phase");
        fail_count++;
    end

    //////////////////////////////////////////////////////////////////////
    // waveform side
    //////////////////////////////////////////////////////////////////////

    // strobe is a single cycle
    a_strobe_single: assert property (@(posedge ep50trig) disable iff (reset_global)
        wave_strobe |=> !wave_strobe)
    else
    begin
        $error("wave_strobe held for two cycles");
        fail_count++;
    end

    // wave holds between strobes
    a_wave_stable: assert property (@(posedge ep50trig) disable iff (reset_global)
        $changed(wave) |-> wave_strobe)
    else
    begin
        $error("wave changed without wave_strobe");
        fail_count++;
    end

    // an in-flight fetch ends within three cycles of run low
    a_stop_drains: assert property (@(posedge ep50trig) disable iff (reset_global)
        (!run) [*4] |-> !wave_strobe)
    else
    begin
        $error("wave_strobe more than three cycles after run low");
        fail_count++;
    end

endmodule

// attach to every top level, run is the internal control wire
bind waveform_gen_top waveform_gen_assertions u_assertions (
    .ep50trig     (ep50trig),
    .reset_global (reset_global),
    .psel         (psel),
    .penable      (penable),
    .pready       (pready),
    .pslverr      (pslverr),
    .run          (run),
    .wave_strobe  (wave_strobe),
    .wave         (wave)
);
